/* dv/mips_commit_props.sv */
module mips_commit_props
    import mips_commit_pkg::*;
(
    input logic             clk,
    input logic             rst_n,
    input logic             in_valid,
    input logic             in_ready,
    input commit_op_e [1:0] op,
    input logic             dmem_req,
    input logic             dmem_wr,
    input logic             dmem_addr_ok,
    input word_t            dmem_addr,
    input word_t            dmem_wdata,
    input logic [1:0]       rf_wen,
    input logic             redirect_valid,
    input logic             exception_valid,
    input logic             exl
);

    // issue rule, one memory op per bundle
    assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && in_ready |-> !(((op[0] == op_load) || (op[0] == op_store))
                                && ((op[1] == op_load) || (op[1] == op_store))))
        else $error("two memory ops in one bundle");

    assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> (op[1] != op_branch) && (op[1] != op_eret))
        else $error("branch or eret in slot 1");

    assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req && !dmem_addr_ok |=> dmem_req && $stable(dmem_addr)
                                      && $stable(dmem_wr) && $stable(dmem_wdata))
        else $error("memory request dropped or changed before addr_ok");

    // a bundle waiting for in_ready stays put
    assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(op))
        else $error("input bundle dropped or changed before in_ready");

    // state right after a reset edge
    assert property (@(posedge clk)
        !rst_n |=> in_ready && !dmem_req && (rf_wen == 2'b00) && !redirect_valid
                   && !exception_valid && !exl)
        else $error("outputs not idle after reset");

endmodule

/* dv/mips_commit_tb.sv */
`include "mips_commit_params.svh"

module mips_commit_tb
    import mips_commit_pkg::*;
();

    localparam int NUM_BUNDLES = 400;
    localparam int MAX_BUNDLE_CYCLES = 40;
    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DELAY = 1;

    typedef struct packed {
        logic [1:0]      wen;
        logic [1:0][4:0] waddr;
        word_t [1:0]     wdata;
        logic            redir;
        word_t           redir_pc;
        logic            exc;
        exc_code_e       code;
    } commit_t;

    logic             clk;
    logic             rst_n;
    logic             int_req;
    logic             in_valid;
    logic             in_ready;
    commit_op_e [1:0] op;
    word_t [1:0]      pc;
    word_t [1:0]      result;
    word_t [1:0]      store_data;
    logic [1:0][4:0]  dest;
    logic [1:0]       overflow;
    logic             dmem_req;
    logic             dmem_wr;
    word_t            dmem_addr;
    word_t            dmem_wdata;
    logic             dmem_addr_ok;
    logic             dmem_data_ok;
    word_t            dmem_rdata;
    logic [1:0]       rf_wen;
    logic [1:0][4:0]  rf_waddr;
    word_t [1:0]      rf_wdata;
    logic             redirect_valid;
    word_t            redirect_pc;
    logic             exception_valid;
    exc_code_e        exception_code;

    logic [31:0] lfsr;
    word_t       mem [16];
    word_t       ref_mem [16];
    word_t       ref_epc;
    logic        ref_exl;
    logic        ref_shadow;
    commit_t     exp_q [$];

    tb_clock #(.PERIOD(CLK_PERIOD)) tb_clock_inst (.clk);

    mips_commit_top mips_commit_top_inst (.*);

    bind commit_stage mips_commit_props mips_commit_props_inst (
        .clk, .rst_n, .in_valid, .in_ready, .op,
        .dmem_req, .dmem_wr, .dmem_addr_ok, .dmem_addr, .dmem_wdata,
        .rf_wen, .redirect_valid, .exception_valid, .exl
    );

    function automatic logic lfsr_step();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 32'hb4bc_d35c;
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    // word 0x100 + 4*i, pattern spread over the whole address
    function automatic word_t fill_word(input int i);
        word_t a;
        a = 32'h100 + 32'(i * 4);
        return (a * 32'h9e37_79b9) ^ 32'hc3c3_0000;
    endfunction

    // expected commit of the bundle now on the inputs
    function automatic commit_t predict_commit();
        commit_t         e;
        logic [1:0]      fault;
        exc_code_e [1:0] code;
        logic [1:0]      live;
        logic            exc;
        logic            slot;
        exc_code_e       ecode;
        word_t           ld;
        e = '0;
        if (ref_shadow)
        begin
            ref_shadow = 1'b0;
            return e;
        end
        for (int i = 0; i < 2; i++)
        begin
            fault[i] = 1'b0;
            code[i] = exc_sys;
            if (op[i] == op_load)
            begin
                fault[i] = result[i][1:0] != 2'b00;
                code[i] = exc_adel;
            end
            else if (op[i] == op_store)
            begin
                fault[i] = result[i][1:0] != 2'b00;
                code[i] = exc_ades;
            end
            else if (op[i] == op_alu)
            begin
                fault[i] = overflow[i];
                code[i] = exc_ov;
            end
            else if (op[i] == op_syscall)
                fault[i] = 1'b1;
        end
        live = 2'b11;
        exc = 1'b0;
        slot = 1'b0;
        ecode = exc_int;
        if (int_req && !ref_exl && op[0] != op_nop)
        begin
            exc = 1'b1;
            live = 2'b00;
        end
        else if (fault[0])
        begin
            exc = 1'b1;
            ecode = code[0];
            live = 2'b00;
        end
        else if (fault[1])
        begin
            exc = 1'b1;
            slot = 1'b1;
            ecode = code[1];
            live[1] = 1'b0;
        end
        ld = '0;
        for (int i = 0; i < 2; i++)
        begin
            if (live[i] && op[i] == op_store)
                ref_mem[result[i][5:2]] = store_data[i];
            if (live[i] && op[i] == op_load)
                ld = ref_mem[result[i][5:2]];
        end
        for (int i = 0; i < 2; i++)
        begin
            e.wen[i] = live[i] && (op[i] == op_alu || op[i] == op_load);
            e.waddr[i] = dest[i];
            e.wdata[i] = (op[i] == op_load) ? ld : result[i];
        end
        if (exc)
        begin
            e.exc = 1'b1;
            e.code = ecode;
            e.redir = 1'b1;
            e.redir_pc = `EXC_VECTOR;
            ref_epc = pc[slot];
            ref_exl = 1'b1;
            ref_shadow = 1'b1;
        end
        else if (op[0] == op_branch)
        begin
            e.redir = 1'b1;
            e.redir_pc = result[0];
            ref_shadow = 1'b1;
        end
        else if (op[0] == op_eret)
        begin
            e.redir = 1'b1;
            e.redir_pc = ref_epc;
            ref_exl = 1'b0;
            ref_shadow = 1'b1;
        end
        return e;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_reg(input string name, input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_code(input string name, input exc_code_e got, input exc_code_e exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    always @(negedge clk)
    begin
        commit_t e;
        if (rst_n && (rf_wen != 2'b00 || redirect_valid || exception_valid))
        begin
            if (exp_q.size() == 0)
                fail_run("commit pulse seen while no commit was expected");
            e = exp_q.pop_front();
            for (int i = 0; i < 2; i++)
            begin
                check_bit($sformatf("rf_wen[%0d]", i), rf_wen[i], e.wen[i]);
                if (e.wen[i])
                begin
                    check_reg($sformatf("rf_waddr[%0d]", i), rf_waddr[i], e.waddr[i]);
                    check_word($sformatf("rf_wdata[%0d]", i), rf_wdata[i], e.wdata[i]);
                end
            end
            check_bit("redirect_valid", redirect_valid, e.redir);
            if (e.redir)
                check_word("redirect_pc", redirect_pc, e.redir_pc);
            check_bit("exception_valid", exception_valid, e.exc);
            if (e.exc)
                check_code("exception_code", exception_code, e.code);
        end
    end

    // memory model, one request outstanding
    initial
    begin
        int    addr_wait;
        int    data_wait;
        logic  pending;
        word_t rd_val;
        dmem_addr_ok = 1'b0;
        dmem_data_ok = 1'b0;
        dmem_rdata = '0;
        pending = 1'b0;
        addr_wait = 0;
        data_wait = 0;
        rd_val = '0;
        forever
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            dmem_addr_ok = 1'b0;
            dmem_data_ok = 1'b0;
            if (pending)
            begin
                if (data_wait == 0)
                begin
                    dmem_data_ok = 1'b1;
                    dmem_rdata = rd_val;
                    pending = 1'b0;
                end
                else
                    data_wait--;
            end
            else if (dmem_req === 1'b1)
            begin
                if (addr_wait == 0)
                begin
                    if (dmem_addr[1:0] != 2'b00)
                        fail_run("memory request sent with a misaligned address");
                    dmem_addr_ok = 1'b1;
                    rd_val = '0;
                    if (dmem_wr)
                        mem[dmem_addr[5:2]] = dmem_wdata;
                    else
                        rd_val = mem[dmem_addr[5:2]];
                    pending = 1'b1;
                    data_wait = rand_bits(2);
                    addr_wait = rand_bits(2);
                end
                else
                    addr_wait--;
            end
        end
    end

    initial
    begin
        #(CLK_PERIOD * (NUM_BUNDLES * MAX_BUNDLE_CYCLES + 20));
        fail_run("watchdog expired before all bundles committed");
    end

    task automatic drain_pipeline();
        int cnt;
        in_valid = 1'b0;
        cnt = 0;
        while (cnt < 2)
        begin
            @(negedge clk);
            if (in_ready)
                cnt++;
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic make_bundle(input word_t base_pc);
        logic [2:0] sel;
        for (int i = 0; i < 2; i++)
        begin
            sel = 3'(rand_bits(3));
            if (i == 0)
                op[i] = (sel == 0) ? op_nop : (sel <= 2) ? op_alu : (sel == 3) ? op_load :
                        (sel == 4) ? op_store : (sel == 5) ? op_branch :
                        (sel == 6) ? op_eret : op_syscall;
            else
                op[i] = (sel == 0) ? op_nop : (sel == 4) ? op_load : (sel == 5) ? op_store :
                        (sel == 6) ? op_syscall : op_alu;
            pc[i] = base_pc + 32'(i * 4);
            dest[i] = 5'(rand_bits(5));
            store_data[i] = rand_bits(32);
            overflow[i] = 1'b0;
            result[i] = rand_bits(32);
        end
        // one memory op per bundle
        if ((op[0] == op_load || op[0] == op_store) && (op[1] == op_load || op[1] == op_store))
            op[1] = op_alu;
        for (int i = 0; i < 2; i++)
        begin
            if (op[i] == op_load || op[i] == op_store)
                result[i] = 32'h100 | (rand_bits(4) << 2)
                          | ((rand_bits(3) == 0) ? rand_bits(2) : 32'd0);
            else if (op[i] == op_branch)
                result[i] = 32'h0040_0000 | (rand_bits(16) << 2);
            else if (op[i] == op_alu)
                overflow[i] = rand_bits(3) == 0;
        end
    endtask

    task automatic send_bundle();
        commit_t e;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready)
            @(negedge clk);
        @(posedge clk);
        #DRIVE_DELAY;
        e = predict_commit();
        // bundles without writes or redirects pulse nothing
        if (e.wen != 2'b00 || e.redir || e.exc)
            exp_q.push_back(e);
        in_valid = 1'b0;
    endtask

    initial
    begin
        word_t base_pc;
        int    gap;
        lfsr = 32'd21;
        rst_n = 1'b0;
        int_req = 1'b0;
        in_valid = 1'b0;
        op[0] = op_nop;
        op[1] = op_nop;
        pc = '0;
        result = '0;
        store_data = '0;
        dest = '0;
        overflow = '0;
        ref_epc = `EPC_RESET;
        ref_exl = 1'b0;
        ref_shadow = 1'b0;
        base_pc = 32'h0040_0000;
        for (int i = 0; i < 16; i++)
        begin
            mem[i] = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        for (int b = 0; b < NUM_BUNDLES; b++)
        begin
            // int_req only changes with the pipeline empty
            if (rand_bits(3) == 0)
            begin
                drain_pipeline();
                int_req = ~int_req;
            end
            gap = (rand_bits(2) == 0) ? int'(rand_bits(2)) : 0;
            repeat (gap)
            begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            make_bundle(base_pc);
            send_bundle();
            base_pc = base_pc + 32'd8;
        end
        drain_pipeline();
        repeat (4) @(posedge clk);
        if (exp_q.size() != 0)
            fail_run($sformatf("%0d expected commits never appeared", exp_q.size()));
        else
        begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

/* dv/tb_clock.sv */
module tb_clock #(
    parameter int PERIOD = 100
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

/* mips_commit.f */
+incdir+rtl
rtl/mips_commit_pkg.sv
rtl/exception_check.sv
rtl/data_commit.sv
rtl/commit_stage.sv
rtl/cp0_regs.sv
rtl/mips_commit_top.sv
dv/tb_clock.sv
dv/mips_commit_props.sv
dv/mips_commit_tb.sv

/* rtl/commit_stage.sv */
module commit_stage
    import mips_commit_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  commit_op_e [1:0] op,
    input  word_t [1:0]      pc,
    input  word_t [1:0]      result,
    input  word_t [1:0]      store_data,
    input  logic [1:0][4:0]  dest,
    input  logic [1:0]       overflow,
    input  logic             int_req,
    input  logic             exl,
    input  word_t            epc,
    output logic             dmem_req,
    output logic             dmem_wr,
    output word_t            dmem_addr,
    output word_t            dmem_wdata,
    input  logic             dmem_addr_ok,
    input  logic             dmem_data_ok,
    input  word_t            dmem_rdata,
    output logic [1:0]       rf_wen,
    output logic [1:0][4:0]  rf_waddr,
    output word_t [1:0]      rf_wdata,
    output logic             redirect_valid,
    output word_t            redirect_pc,
    output logic             exception_valid,
    output exc_code_e        exception_code,
    output logic             exc_commit,
    output word_t            exc_pc,
    output exc_code_e        exc_code,
    output logic             eret_commit
);

    logic             finish;
    logic             c1_done;
    logic             c2_done;
    logic             shadow;
    logic             c1_valid;
    logic             c1_dead;
    commit_op_e [1:0] c1_op;
    word_t [1:0]      c1_pc;
    word_t [1:0]      c1_result;
    word_t [1:0]      c1_store_data;
    logic [1:0][4:0]  c1_dest;
    logic [1:0]       c1_overflow;
    logic [1:0]       c1_live;
    logic             c1_exc_valid;
    logic             c1_exc_slot;
    exc_code_e        c1_exc_code;
    logic             c1_redirect;
    logic             c1_mem_slot;
    logic             c2_valid;
    commit_op_e [1:0] c2_op;
    word_t [1:0]      c2_pc;
    word_t [1:0]      c2_result;
    logic [1:0][4:0]  c2_dest;
    logic [1:0]       c2_live;
    logic             c2_exc_valid;
    logic             c2_exc_slot;
    exc_code_e        c2_exc_code;
    logic             c2_mem_slot;

    assign finish = c1_done & c2_done;
    assign in_ready = finish;
    assign c1_mem_slot = (c1_op[1] == op_load) | (c1_op[1] == op_store);

    // shadow marks the next accepted bundle as wrong-path
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            c1_valid <= 1'b0;
            c1_dead <= 1'b0;
            shadow <= 1'b0;
            c2_valid <= 1'b0;
        end
        else if (finish)
        begin
            c1_valid <= in_valid;
            c2_valid <= c1_valid;
            if (in_valid)
            begin
                c1_dead <= shadow | c1_redirect;
                shadow <= 1'b0;
            end
            else
                shadow <= shadow | c1_redirect;
        end
    end

    always_ff @(posedge clk)
    begin
        if (finish)
        begin
            if (in_valid)
            begin
                c1_op <= op;
                c1_pc <= pc;
                c1_result <= result;
                c1_store_data <= store_data;
                c1_dest <= dest;
                c1_overflow <= overflow;
            end
            c2_op <= c1_op;
            c2_pc <= c1_pc;
            c2_result <= c1_result;
            c2_dest <= c1_dest;
            c2_live <= c1_live;
            c2_exc_valid <= c1_exc_valid;
            c2_exc_slot <= c1_exc_slot;
            c2_exc_code <= c1_exc_code;
            c2_mem_slot <= c1_mem_slot;
        end
    end

    exception_check exception_check_inst (
        .clk, .rst_n,
        .stall(~finish), .dead(c1_dead | ~c1_valid),
        .op(c1_op), .result(c1_result), .store_data(c1_store_data),
        .overflow(c1_overflow), .int_req, .exl, .dmem_addr_ok,
        .live(c1_live), .exc_valid(c1_exc_valid), .exc_slot(c1_exc_slot),
        .exc_code(c1_exc_code), .redirect_taken(c1_redirect),
        .dmem_req, .dmem_wr, .dmem_addr, .dmem_wdata, .c1_done
    );

    data_commit data_commit_inst (
        .clk, .rst_n, .finish, .c2_valid,
        .live(c2_live), .exc_valid(c2_exc_valid), .exc_slot(c2_exc_slot),
        .exc_code(c2_exc_code), .op(c2_op), .pc(c2_pc), .result(c2_result),
        .dest(c2_dest), .mem_slot(c2_mem_slot), .epc, .dmem_data_ok, .dmem_rdata,
        .c2_done, .rf_wen, .rf_waddr, .rf_wdata, .redirect_valid, .redirect_pc,
        .exception_valid, .exception_code, .exc_commit, .exc_pc, .eret_commit
    );

    assign exc_code = c2_exc_code;

endmodule

/* rtl/cp0_regs.sv */
`include "mips_commit_params.svh"

module cp0_regs
    import mips_commit_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      exc_commit,
    input  word_t     exc_pc,
    input  exc_code_e exc_code,
    input  logic      eret_commit,
    output word_t     epc,
    output logic      exl
);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            epc <= `EPC_RESET;
            exl <= 1'b0;
        end
        else if (exc_commit)
        begin
            epc <= exc_pc;
            exl <= 1'b1;
        end
        else if (eret_commit)
            exl <= 1'b0;
    end

endmodule

/* rtl/data_commit.sv */
`include "mips_commit_params.svh"

module data_commit
    import mips_commit_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             finish,
    input  logic             c2_valid,
    input  logic [1:0]       live,
    input  logic             exc_valid,
    input  logic             exc_slot,
    input  exc_code_e        exc_code,
    input  commit_op_e [1:0] op,
    input  word_t [1:0]      pc,
    input  word_t [1:0]      result,
    input  logic [1:0][4:0]  dest,
    input  logic             mem_slot,
    input  word_t            epc,
    input  logic             dmem_data_ok,
    input  word_t            dmem_rdata,
    output logic             c2_done,
    output logic [1:0]       rf_wen,
    output logic [1:0][4:0]  rf_waddr,
    output word_t [1:0]      rf_wdata,
    output logic             redirect_valid,
    output word_t            redirect_pc,
    output logic             exception_valid,
    output exc_code_e        exception_code,
    output logic             exc_commit,
    output word_t            exc_pc,
    output logic             eret_commit
);

    mem_state_e state;
    word_t      load_data;
    word_t      load_word;
    logic       mem_live;
    logic       commit;
    logic       branch_commit;

    assign commit = finish & c2_valid;
    assign mem_live = c2_valid & live[mem_slot]
                    & ((op[mem_slot] == op_load) | (op[mem_slot] == op_store));
    assign c2_done = ~mem_live | (state == mem_data) | dmem_data_ok;

    // hold early load data until both stages finish
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= mem_idle;
        else if (finish)
            state <= mem_idle;
        else if (mem_live && dmem_data_ok && state == mem_idle)
            state <= mem_data;
    end

    always_ff @(posedge clk)
    begin
        if (state == mem_idle && dmem_data_ok)
            load_data <= dmem_rdata;
    end

    assign load_word = (state == mem_data) ? load_data : dmem_rdata;

    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            rf_wen[i] = commit & live[i] & ((op[i] == op_alu) | (op[i] == op_load));
            rf_waddr[i] = dest[i];
            rf_wdata[i] = (op[i] == op_load) ? load_word : result[i];
        end
    end

    assign exception_valid = commit & exc_valid;
    assign exception_code = exc_code;
    assign exc_commit = exception_valid;
    assign exc_pc = pc[exc_slot];

    assign eret_commit = commit & ~exc_valid & live[0] & (op[0] == op_eret);
    assign branch_commit = commit & ~exc_valid & live[0] & (op[0] == op_branch);

    assign redirect_valid = exception_valid | eret_commit | branch_commit;
    assign redirect_pc = exc_valid ? `EXC_VECTOR : ((op[0] == op_eret) ? epc : result[0]);

endmodule

/* rtl/exception_check.sv */
module exception_check
    import mips_commit_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stall,
    input  logic             dead,
    input  commit_op_e [1:0] op,
    input  word_t [1:0]      result,
    input  word_t [1:0]      store_data,
    input  logic [1:0]       overflow,
    input  logic             int_req,
    input  logic             exl,
    input  logic             dmem_addr_ok,
    output logic [1:0]       live,
    output logic             exc_valid,
    output logic             exc_slot,
    output exc_code_e        exc_code,
    output logic             redirect_taken,
    output logic             dmem_req,
    output logic             dmem_wr,
    output word_t            dmem_addr,
    output word_t            dmem_wdata,
    output logic             c1_done
);

    mem_state_e      state;
    logic [1:0]      fault;
    exc_code_e [1:0] fault_code;
    logic            int_take;
    logic            mem_slot;
    logic            need_req;

    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            fault[i] = 1'b0;
            fault_code[i] = exc_sys;
            case (op[i])
                op_load:
                begin
                    fault[i] = |result[i][1:0];
                    fault_code[i] = exc_adel;
                end
                op_store:
                begin
                    fault[i] = |result[i][1:0];
                    fault_code[i] = exc_ades;
                end
                op_alu:
                begin
                    fault[i] = overflow[i];
                    fault_code[i] = exc_ov;
                end
                op_syscall:
                    fault[i] = 1'b1;
                default:
                    fault[i] = 1'b0;
            endcase
        end
    end

    // no interrupt once the request is out
    assign int_take = ~dead & ~exl & int_req & (op[0] != op_nop) & (state == mem_idle);

    always_comb
    begin
        exc_valid = 1'b0;
        exc_slot = 1'b0;
        exc_code = exc_int;
        live = dead ? 2'b00 : 2'b11;
        if (!dead)
        begin
            if (int_take)
            begin
                exc_valid = 1'b1;
                live = 2'b00;
            end
            else if (fault[0])
            begin
                exc_valid = 1'b1;
                exc_code = fault_code[0];
                live = 2'b00;
            end
            else if (fault[1])
            begin
                exc_valid = 1'b1;
                exc_slot = 1'b1;
                exc_code = fault_code[1];
                live[1] = 1'b0;
            end
        end
    end

    assign mem_slot = (op[1] == op_load) | (op[1] == op_store);
    assign need_req = live[mem_slot] & ((op[mem_slot] == op_load) | (op[mem_slot] == op_store));

    assign dmem_req = need_req & (state != mem_data);
    assign dmem_wr = op[mem_slot] == op_store;
    assign dmem_addr = result[mem_slot];
    assign dmem_wdata = store_data[mem_slot];

    assign c1_done = ~need_req | (state == mem_data) | dmem_addr_ok;
    assign redirect_taken = exc_valid | (live[0] & ((op[0] == op_branch) | (op[0] == op_eret)));

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= mem_idle;
        else
        begin
            case (state)
                mem_idle, mem_addr:
                    if (dmem_req)
                        state <= dmem_addr_ok ? (stall ? mem_data : mem_idle) : mem_addr;
                mem_data:
                    if (!stall)
                        state <= mem_idle;
                default:
                    state <= mem_idle;
            endcase
        end
    end

endmodule

/* rtl/mips_commit_params.svh */
`ifndef MIPS_COMMIT_PARAMS_SVH
`define MIPS_COMMIT_PARAMS_SVH

// data and address width
`define DATA_WIDTH 32

// fetch target on any exception
`define EXC_VECTOR 32'hbfc0_0380

// epc value out of reset
`define EPC_RESET 32'hbfc0_0000

`endif

/* rtl/mips_commit_pkg.sv */
`include "mips_commit_params.svh"

package mips_commit_pkg;

    typedef logic [`DATA_WIDTH-1:0] word_t;

    typedef enum logic [2:0] {
        op_nop,
        op_alu,
        op_load,
        op_store,
        op_branch,
        op_eret,
        op_syscall
    } commit_op_e;

    // MIPS cause encodings
    typedef enum logic [4:0] {
        exc_int  = 5'd0,
        exc_adel = 5'd4,
        exc_ades = 5'd5,
        exc_sys  = 5'd8,
        exc_ov   = 5'd12
    } exc_code_e;

    typedef enum logic [1:0] {
        mem_idle,
        mem_addr,
        mem_data
    } mem_state_e;

endpackage

/* rtl/mips_commit_top.sv */
module mips_commit_top
    import mips_commit_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             int_req,
    input  logic             in_valid,
    output logic             in_ready,
    input  commit_op_e [1:0] op,
    input  word_t [1:0]      pc,
    input  word_t [1:0]      result,
    input  word_t [1:0]      store_data,
    input  logic [1:0][4:0]  dest,
    input  logic [1:0]       overflow,
    output logic             dmem_req,
    output logic             dmem_wr,
    output word_t            dmem_addr,
    output word_t            dmem_wdata,
    input  logic             dmem_addr_ok,
    input  logic             dmem_data_ok,
    input  word_t            dmem_rdata,
    output logic [1:0]       rf_wen,
    output logic [1:0][4:0]  rf_waddr,
    output word_t [1:0]      rf_wdata,
    output logic             redirect_valid,
    output word_t            redirect_pc,
    output logic             exception_valid,
    output exc_code_e        exception_code
);

    word_t     epc;
    logic      exl;
    logic      exc_commit;
    word_t     exc_pc;
    exc_code_e exc_code;
    logic      eret_commit;

    commit_stage commit_stage_inst (
        .clk, .rst_n, .in_valid, .in_ready,
        .op, .pc, .result, .store_data, .dest, .overflow,
        .int_req, .exl, .epc,
        .dmem_req, .dmem_wr, .dmem_addr, .dmem_wdata,
        .dmem_addr_ok, .dmem_data_ok, .dmem_rdata,
        .rf_wen, .rf_waddr, .rf_wdata, .redirect_valid, .redirect_pc,
        .exception_valid, .exception_code,
        .exc_commit, .exc_pc, .exc_code, .eret_commit
    );

    cp0_regs cp0_regs_inst (
        .clk, .rst_n, .exc_commit, .exc_pc, .exc_code, .eret_commit,
        .epc, .exl
    );

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module mips_commit_tb -f mips_commit.f -o mips_commit_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/mips_commit_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -qF "*** FAILED ***" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
